// File: sources.f
hps_io_pkg.sv
host_cmd_framer.sv
host_setting_regs.sv
ps2_key_decoder.sv
file_loader.sv
hps_io.sv
hps_io_checker.sv
hps_io_tb.sv

// File: hps_io_tb.sv
`timescale 1ns/100ps

module hps_io_tb;

	logic        clk_sys;
	logic        rst;
	logic        io_enable;
	logic        io_strobe;
	logic [15:0] io_din;
	logic        fp_enable;
	logic [15:0] io_dout;
	logic        io_wait;
	logic [1:0]  buttons;
	logic        forced_scandoubler;
	logic        direct_video;
	logic [31:0] joystick_0;
	logic [31:0] joystick_1;
	logic [63:0] status;
	logic [63:0] status_in;
	logic        status_set;
	logic [10:0] ps2_key;
	logic        ioctl_download;
	logic [15:0] ioctl_index;
	logic [26:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic        ioctl_wr;
	logic        ioctl_wait;

	// stimulus table, one transfer per row
	// args hold argument words with the first one in [15:0]
	// reply holds io_dout per word with the command word in [15:0]
	// exp_v holds what the command sets
	// {direct_video, forced_scandoubler, buttons} for config, {download, addr} for start/stop
	// and the first write address for data
	logic        row_file  [0:15];
	logic [15:0] row_cmd   [0:15];
	int          row_nargs [0:15];
	logic [63:0] row_args  [0:15];
	logic [79:0] row_reply [0:15];
	logic [63:0] row_exp   [0:15];
	int          row_nwr   [0:15];
	int          n_rows;

	// current row as seen by the checker
	int          cur_row;
	logic [15:0] exp_cmd;
	logic [63:0] exp_args;
	logic [79:0] exp_reply;
	logic [63:0] exp_out;
	int          exp_wr;
	int          rows_done;
	int          pass_cnt;
	int          fail_cnt;
	logic        hung;

	always #4 clk_sys = ~clk_sys;

	hps_io dut_i (
		.clk_sys            (clk_sys),
		.rst                (rst),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.fp_enable          (fp_enable),
		.io_dout            (io_dout),
		.io_wait            (io_wait),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.status_in          (status_in),
		.status_set         (status_set),
		.ps2_key            (ps2_key),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout),
		.ioctl_wr           (ioctl_wr),
		.ioctl_wait         (ioctl_wait)
	);

	hps_io_checker checker_i (
		.clk_sys            (clk_sys),
		.rst                (rst),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.fp_enable          (fp_enable),
		.io_dout            (io_dout),
		.io_wait            (io_wait),
		.ioctl_wait         (ioctl_wait),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ps2_key            (ps2_key),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout),
		.ioctl_wr           (ioctl_wr),
		.row                (cur_row),
		.exp_cmd            (exp_cmd),
		.exp_args           (exp_args),
		.exp_reply          (exp_reply),
		.exp_out            (exp_out),
		.exp_wr             (exp_wr),
		.rows_done          (rows_done),
		.pass_cnt           (pass_cnt),
		.fail_cnt           (fail_cnt)
	);

	task automatic add_row(input logic file_ch, input logic [15:0] cmd, input int nargs,
			input logic [63:0] args, input logic [79:0] reply, input logic [63:0] exp_v,
			input int nwr);
		row_file[n_rows]  = file_ch;
		row_cmd[n_rows]   = cmd;
		row_nargs[n_rows] = nargs;
		row_args[n_rows]  = args;
		row_reply[n_rows] = reply;
		row_exp[n_rows]   = exp_v;
		row_nwr[n_rows]   = nwr;
		n_rows++;
	endtask

	task automatic fill_table;
		n_rows = 0;
		add_row(1'b0, hps_io_pkg::cmd_cfg, 1, 64'h0413, 80'h0, 64'hF, 0);
		add_row(1'b0, hps_io_pkg::cmd_joy0, 2, 64'hABCD_1234, 80'h0, 64'hABCD_1234, 0);
		add_row(1'b0, hps_io_pkg::cmd_joy1, 2, 64'h9EF0_5678, 80'h0, 64'h9EF0_5678, 0);
		add_row(1'b0, hps_io_pkg::cmd_status, 4, 64'h4444_3333_2222_1111, 80'h0,
			64'h4444_3333_2222_1111, 0);
		// tag A and a count of two followed by the snapshot slices
		add_row(1'b0, hps_io_pkg::cmd_status_req, 4, 64'h0,
			80'hFEDC_BA98_7654_3210_00A2, 64'h0, 0);
		add_row(1'b0, hps_io_pkg::cmd_key, 1, 64'h001C, 80'h0, 64'h61C, 0);
		add_row(1'b0, hps_io_pkg::cmd_key, 3, 64'h0075_00F0_00E0, 80'h0, 64'h175, 0);
		add_row(1'b0, hps_io_pkg::cmd_key, 4, 64'h007C_00E0_0012_00E0, 80'h0, 64'h77C, 0);
		// marker word leaves the event unchanged
		add_row(1'b0, hps_io_pkg::cmd_key, 2, 64'hFF00_0011, 80'h0, 64'h77C, 0);
		add_row(1'b1, {8'h00, hps_io_pkg::fio_index}, 1, 64'h7, 80'h0, 64'h7, 0);
		add_row(1'b1, {8'h00, hps_io_pkg::fio_tx}, 3, 64'h0000_0100_0001, 80'h0,
			64'h0800_0100, 0);
		add_row(1'b1, {8'h00, hps_io_pkg::fio_tx_dat}, 3, 64'h0017_00C3_005A, 80'h0,
			64'h100, 3);
		// stop leaves the next write address on ioctl_addr
		add_row(1'b1, {8'h00, hps_io_pkg::fio_tx}, 1, 64'h0, 80'h0, 64'h103, 0);
	endtask

	////////////////////////////////////////////////////////////
	// host model
	////////////////////////////////////////////////////////////

	// random core stalls
	// the strobe goes out once io_wait has been low for a full cycle
	task automatic wait_host_ready;
		int n;
		n = 0;
		ioctl_wait = ($urandom % 3) == 0;
		@(negedge clk_sys);
		while (io_wait && n < 200) begin
			@(posedge clk_sys);
			#1;
			ioctl_wait = ($urandom % 3) == 0;
			n++;
			@(negedge clk_sys);
		end
		if (io_wait) begin
			$display("io_wait stuck high for 200 cycles, row %0d", cur_row);
			hung = 1'b1;
		end
		@(posedge clk_sys);
		#1;
	endtask

	task automatic send_word(input logic [15:0] w);
		wait_host_ready();
		if (!hung) begin
			io_strobe = 1'b1;
			io_din    = w;
			@(posedge clk_sys);
			#1;
			io_strobe = 1'b0;
		end
	endtask

	task automatic run_transfer(input int r);
		int i;
		if (row_file[r]) begin
			fp_enable = 1'b1;
		end else begin
			io_enable = 1'b1;
		end
		send_word(row_cmd[r]);
		for (i = 0; i < row_nargs[r]; i++) begin
			send_word(row_args[r][i*16 +: 16]);
		end
		// reply to the last word is read while the enable is still high
		@(posedge clk_sys);
		#1;
		io_enable = 1'b0;
		fp_enable = 1'b0;
	endtask

	task automatic wait_row_checked(input int target);
		int n;
		n = 0;
		while (rows_done < target && n < 20) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		if (rows_done < target) begin
			$display("checker gave no result for row %0d within 20 cycles", target - 1);
			hung = 1'b1;
		end
	endtask

	task automatic pulse_status_set;
		@(posedge clk_sys);
		#1;
		status_set = 1'b1;
		@(posedge clk_sys);
		#1;
		status_set = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int r;
		ioctl_wait = ($urandom(32'h41804569) % 3) == 0;
		clk_sys    = 1'b0;
		rst        = 1'b1;
		io_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		fp_enable  = 1'b0;
		status_in  = '0;
		status_set = 1'b0;
		hung       = 1'b0;
		cur_row    = 0;
		exp_cmd    = '0;
		exp_args   = '0;
		exp_reply  = '0;
		exp_out    = '0;
		exp_wr     = 0;
		fill_table();
		repeat (2) @(posedge clk_sys);
		#1;
		rst = 1'b0;

		// only the second of two snapshots is read back
		status_in = 64'h0BAD_0BAD_0BAD_0BAD;
		pulse_status_set();
		status_in = 64'hFEDC_BA98_7654_3210;
		pulse_status_set();

		for (r = 0; r < n_rows && !hung; r++) begin
			cur_row   = r;
			exp_cmd   = row_cmd[r];
			exp_args  = row_args[r];
			exp_reply = row_reply[r];
			exp_out   = row_exp[r];
			exp_wr    = row_nwr[r];
			run_transfer(r);
			wait_row_checked(r + 1);
		end

		$display("rows passed %0d, rows failed %0d", pass_cnt, fail_cnt);
		if (!hung && fail_cnt == 0 && pass_cnt == n_rows) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: hps_io_checker.sv
`timescale 1ns/100ps

module hps_io_checker (
	input  logic        clk_sys,
	input  logic        rst,
	input  logic        io_enable,
	input  logic        io_strobe,
	input  logic        fp_enable,
	input  logic [15:0] io_dout,
	input  logic        io_wait,
	input  logic        ioctl_wait,
	input  logic [1:0]  buttons,
	input  logic        forced_scandoubler,
	input  logic        direct_video,
	input  logic [31:0] joystick_0,
	input  logic [31:0] joystick_1,
	input  logic [63:0] status,
	input  logic [10:0] ps2_key,
	input  logic        ioctl_download,
	input  logic [15:0] ioctl_index,
	input  logic [26:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	input  logic        ioctl_wr,

	// expected values of the current row
	input  int          row,
	input  logic [15:0] exp_cmd,
	input  logic [63:0] exp_args,
	input  logic [79:0] exp_reply,
	input  logic [63:0] exp_out,
	input  int          exp_wr,

	output int          rows_done,
	output int          pass_cnt,
	output int          fail_cnt
);

	logic cmd_stb_d;
	logic busy_d;
	logic end_due;
	int   word_n;
	int   wr_n;
	int   row_err;

	task automatic check_value(input string what, input logic [63:0] got_v,
			input logic [63:0] exp_v);
		if (got_v !== exp_v) begin
			$display("ERROR %0t: row %0d %s is %0h, expected %0h", $time, row, what,
				got_v, exp_v);
			row_err++;
		end
	endtask

	// settings are compared against what the row's command writes
	task automatic check_row_end;
		case (exp_cmd)
			hps_io_pkg::cmd_cfg:
				check_value("config", {direct_video, forced_scandoubler, buttons}, exp_out[3:0]);
			hps_io_pkg::cmd_joy0: check_value("joystick_0", joystick_0, exp_out[31:0]);
			hps_io_pkg::cmd_joy1: check_value("joystick_1", joystick_1, exp_out[31:0]);
			hps_io_pkg::cmd_status: check_value("status", status, exp_out);
			hps_io_pkg::cmd_key: check_value("ps2_key", ps2_key, exp_out[10:0]);
			{8'h00, hps_io_pkg::fio_index}:
				check_value("ioctl_index", ioctl_index, exp_out[15:0]);
			{8'h00, hps_io_pkg::fio_tx}:
				check_value("download/addr", {ioctl_download, ioctl_addr}, exp_out[27:0]);
			{8'h00, hps_io_pkg::fio_tx_dat}:
				check_value("ioctl_download", ioctl_download, 64'h1);
			default: ;
		endcase
		if (wr_n != exp_wr) begin
			$display("ERROR %0t: row %0d gave %0d ioctl_wr pulses, expected %0d", $time, row,
				wr_n, exp_wr);
			row_err++;
		end
		if (row_err == 0) begin
			$display("row %0d passed", row);
			pass_cnt <= pass_cnt + 1;
		end else begin
			$display("row %0d failed with %0d errors", row, row_err);
			fail_cnt <= fail_cnt + 1;
		end
		rows_done <= rows_done + 1;
		row_err = 0;
		word_n  = 0;
		wr_n    = 0;
	endtask

	always @(posedge clk_sys) begin
		if (rst) begin
			cmd_stb_d = 1'b0;
			busy_d    = 1'b0;
			end_due   = 1'b0;
			word_n    = 0;
			wr_n      = 0;
			row_err   = 0;
			rows_done <= 0;
			pass_cnt  <= 0;
			fail_cnt  <= 0;
		end else begin
			// stall seen by the host follows the core's stall
			check_value("io_wait", io_wait, ioctl_wait);

			// reply to the word strobed one cycle ago
			if (cmd_stb_d) begin
				check_value("io_dout", io_dout, exp_reply[word_n*16 +: 16]);
				word_n++;
			end
			cmd_stb_d = io_enable && io_strobe;

			if (ioctl_wr) begin
				$display("%0t: ioctl_wr addr %h data %h", $time, ioctl_addr, ioctl_dout);
				if (exp_cmd == {8'h00, hps_io_pkg::fio_tx_dat} && wr_n < exp_wr) begin
					check_value("ioctl_addr", ioctl_addr, exp_out[26:0] + wr_n);
					check_value("ioctl_dout", ioctl_dout, exp_args[wr_n*16 +: 8]);
				end
				wr_n++;
			end

			// second edge after the enable fell
			if (end_due) begin
				check_row_end();
			end
			end_due = busy_d && !(io_enable || fp_enable);
			busy_d  = io_enable || fp_enable;
		end
	end

endmodule

// File: hps_io.sv
`timescale 1ns/100ps

module hps_io (
	input  logic        clk_sys,
	input  logic        rst,

	// host side
	input  logic        io_enable,
	input  logic        io_strobe,
	input  logic [15:0] io_din,
	input  logic        fp_enable,
	output logic [15:0] io_dout,
	output logic        io_wait,

	// core settings
	output logic [1:0]  buttons,
	output logic        forced_scandoubler,
	output logic        direct_video,
	output logic [31:0] joystick_0,
	output logic [31:0] joystick_1,
	output logic [63:0] status,
	input  logic [63:0] status_in,
	input  logic        status_set,

	// keyboard events
	output logic [10:0] ps2_key,

	// download port
	output logic        ioctl_download,
	output logic [15:0] ioctl_index,
	output logic [26:0] ioctl_addr,
	output logic [7:0]  ioctl_dout,
	output logic        ioctl_wr,
	input  logic        ioctl_wait
);

	logic                        word_stb;
	logic [hps_io_pkg::cnt_w-1:0] word_idx;
	logic [15:0]                 word_data;
	logic [15:0]                 cmd;
	logic                        frame_end;

	// core stall goes straight back to the host
	assign io_wait = ioctl_wait;

	host_cmd_framer framer_i (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.io_enable (io_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.word_stb  (word_stb),
		.word_idx  (word_idx),
		.word_data (word_data),
		.cmd       (cmd),
		.frame_end (frame_end)
	);

	host_setting_regs regs_i (
		.clk_sys            (clk_sys),
		.rst                (rst),
		.io_enable          (io_enable),
		.word_stb           (word_stb),
		.word_idx           (word_idx),
		.word_data          (word_data),
		.cmd                (cmd),
		.status_in          (status_in),
		.status_set         (status_set),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status)
	);

	ps2_key_decoder key_i (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.word_stb  (word_stb),
		.word_idx  (word_idx),
		.word_data (word_data),
		.cmd       (cmd),
		.frame_end (frame_end),
		.ps2_key   (ps2_key)
	);

	file_loader loader_i (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.fp_enable      (fp_enable),
		.io_strobe      (io_strobe),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr)
	);

endmodule

// File: file_loader.sv
`timescale 1ns/100ps

module file_loader (
	input  logic                          clk_sys,
	input  logic                          rst,
	input  logic                          fp_enable,
	input  logic                          io_strobe,
	input  logic [15:0]                   io_din,
	output logic                          ioctl_download,
	output logic [15:0]                   ioctl_index,
	output logic [hps_io_pkg::addr_w-1:0] ioctl_addr,
	output logic [hps_io_pkg::data_w-1:0] ioctl_dout,
	output logic                          ioctl_wr
);

	logic                          has_cmd;
	logic [15:0]                   cmd;
	// argument number within the transfer, sticks at 3
	logic [1:0]                    arg_cnt;
	// next write address
	logic [hps_io_pkg::addr_w-1:0] addr;
	logic                          wr_arm;

	////////////////////////////////////////////////////////////
	// control state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			has_cmd        <= 1'b0;
			arg_cnt        <= '0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			wr_arm         <= 1'b0;
			ioctl_wr       <= 1'b0;
		end else begin
			// write strobe trails the data strobe by two clocks
			ioctl_wr <= wr_arm;
			wr_arm   <= 1'b0;
			if (!fp_enable) begin
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
					arg_cnt <= '0;
				end else begin
					if (arg_cnt != '1) begin
						arg_cnt <= arg_cnt + 1'b1;
					end
					case (cmd)
						{8'h00, hps_io_pkg::fio_index}: begin
							ioctl_index <= io_din;
						end
						{8'h00, hps_io_pkg::fio_tx}: begin
							if (arg_cnt == 2'd0) begin
								ioctl_download <= io_din[7:0] != 8'h00;
							end
						end
						{8'h00, hps_io_pkg::fio_tx_dat}: begin
							wr_arm <= ioctl_download;
						end
						default: ;
					endcase
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// command, address and data path
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (fp_enable && io_strobe) begin
			if (!has_cmd) begin
				cmd <= io_din;
			end else if (cmd == {8'h00, hps_io_pkg::fio_tx}) begin
				case (arg_cnt)
					2'd0: begin
						if (io_din[7:0] != 8'h00) begin
							addr <= '0;
						end else if (ioctl_download) begin
							// stop, leave the final address visible
							ioctl_addr <= addr;
						end
					end
					2'd1: begin
						ioctl_addr[15:0] <= io_din;
						addr[15:0]       <= io_din;
					end
					2'd2: begin
						ioctl_addr[hps_io_pkg::addr_w-1:16] <= io_din[hps_io_pkg::addr_w-17:0];
						addr[hps_io_pkg::addr_w-1:16]       <= io_din[hps_io_pkg::addr_w-17:0];
					end
					default: ;
				endcase
			end else if (cmd == {8'h00, hps_io_pkg::fio_tx_dat} && ioctl_download) begin
				ioctl_addr <= addr;
				ioctl_dout <= io_din[hps_io_pkg::data_w-1:0];
				addr       <= addr + 1'b1;
			end
		end
	end

	wr_single_a : assert property (
		@(posedge clk_sys) disable iff (rst)
		ioctl_wr |=> !ioctl_wr
	);

	wr_in_download_a : assert property (
		@(posedge clk_sys) disable iff (rst)
		ioctl_wr |-> ioctl_download
	);

endmodule

// File: ps2_key_decoder.sv
`timescale 1ns/100ps

module ps2_key_decoder (
	input  logic                         clk_sys,
	input  logic                         rst,
	input  logic                         word_stb,
	input  logic [hps_io_pkg::cnt_w-1:0] word_idx,
	input  logic [15:0]                  word_data,
	input  logic [15:0]                  cmd,
	input  logic                         frame_end,
	output logic [10:0]                  ps2_key
);

	// last four bytes of the transfer, newest in [7:0]
	logic [31:0] key_raw;
	logic        skip;
	logic        pressed;
	logic        extended;
	logic        key_arg;

	assign key_arg = word_stb && word_idx != '0 && cmd == hps_io_pkg::cmd_key;

	assign pressed  = key_raw[15:8] != hps_io_pkg::key_break;
	assign extended = pressed ? (key_raw[15:8] == hps_io_pkg::key_ext)
	                          : (key_raw[23:16] == hps_io_pkg::key_ext);

	// byte collection
	always_ff @(posedge clk_sys) begin
		if (word_stb && word_idx == '0 && word_data == hps_io_pkg::cmd_key) begin
			key_raw <= '0;
		end else if (key_arg && !(&word_data[15:8]) && !skip) begin
			key_raw <= {key_raw[23:0], word_data[7:0]};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst || frame_end) begin
			skip <= 1'b0;
		end else if (word_stb && word_idx == '0) begin
			skip <= 1'b0;
		end else if (key_arg && (&word_data[15:8])) begin
			// marker word, drop this whole transfer
			skip <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// event build at end of transfer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ps2_key <= '0;
		end else if (frame_end && cmd == hps_io_pkg::cmd_key && !skip) begin
			ps2_key <= {~ps2_key[10], pressed, extended, key_raw[7:0]};
			// multi byte keys get a fixed code
			if (key_raw == hps_io_pkg::key_prnscr_make) begin
				ps2_key[9:0] <= hps_io_pkg::key_prnscr_code;
			end
			if (key_raw == hps_io_pkg::key_prnscr_break) begin
				ps2_key[9:0] <= {1'b0, hps_io_pkg::key_prnscr_code[8:0]};
			end
			if (key_raw == hps_io_pkg::key_pause_make) begin
				ps2_key[9:0] <= hps_io_pkg::key_pause_code;
			end
		end
	end

	// event toggle only follows the end of a transfer
	toggle_after_end_a : assert property (
		@(posedge clk_sys) disable iff (rst)
		$changed(ps2_key[10]) |-> $past(frame_end)
	);

endmodule

// File: host_setting_regs.sv
`timescale 1ns/100ps

module host_setting_regs (
	input  logic                         clk_sys,
	input  logic                         rst,
	input  logic                         io_enable,
	input  logic                         word_stb,
	input  logic [hps_io_pkg::cnt_w-1:0] word_idx,
	input  logic [15:0]                  word_data,
	input  logic [15:0]                  cmd,
	input  logic [63:0]                  status_in,
	input  logic                         status_set,
	output logic [15:0]                  io_dout,
	output logic [1:0]                   buttons,
	output logic                         forced_scandoubler,
	output logic                         direct_video,
	output logic [31:0]                  joystick_0,
	output logic [31:0]                  joystick_1,
	output logic [63:0]                  status
);

	logic [15:0] cfg;

	// status request side
	logic        status_set_d;
	logic [3:0]  req_cnt;
	logic [63:0] status_req;

	// cfg bits not mapped here are handled outside the core
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	////////////////////////////////////////////////////////////
	// settings written by the host
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (word_stb && word_idx != '0) begin
			case (cmd)
				hps_io_pkg::cmd_cfg: begin
					cfg <= word_data;
				end
				hps_io_pkg::cmd_joy0: begin
					if (word_idx == 4'd1) begin
						joystick_0[15:0] <= word_data;
					end else if (word_idx == 4'd2) begin
						joystick_0[31:16] <= word_data;
					end
				end
				hps_io_pkg::cmd_joy1: begin
					if (word_idx == 4'd1) begin
						joystick_1[15:0] <= word_data;
					end else if (word_idx == 4'd2) begin
						joystick_1[31:16] <= word_data;
					end
				end
				hps_io_pkg::cmd_status: begin
					// low slice first
					case (word_idx)
						4'd1: status[15:0]  <= word_data;
						4'd2: status[31:16] <= word_data;
						4'd3: status[47:32] <= word_data;
						4'd4: status[63:48] <= word_data;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// status request capture
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			status_set_d <= 1'b0;
			req_cnt      <= '0;
		end else begin
			status_set_d <= status_set;
			if (status_set && !status_set_d) begin
				req_cnt <= req_cnt + 1'b1;
			end
		end
	end

	// status_in as seen at the latest request
	always_ff @(posedge clk_sys) begin
		if (status_set && !status_set_d) begin
			status_req <= status_in;
		end
	end

	////////////////////////////////////////////////////////////
	// read data back to the host
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst || !io_enable) begin
			io_dout <= '0;
		end else if (word_stb) begin
			io_dout <= '0;
			if (word_idx == '0) begin
				// answer on the command word itself
				if (word_data == hps_io_pkg::cmd_status_req) begin
					io_dout <= {8'h00, hps_io_pkg::req_tag, req_cnt};
				end
			end else if (cmd == hps_io_pkg::cmd_status_req) begin
				case (word_idx)
					4'd1: io_dout <= status_req[15:0];
					4'd2: io_dout <= status_req[31:16];
					4'd3: io_dout <= status_req[47:32];
					4'd4: io_dout <= status_req[63:48];
					default: ;
				endcase
			end
		end
	end

endmodule

// File: host_cmd_framer.sv
`timescale 1ns/100ps

module host_cmd_framer (
	input  logic                         clk_sys,
	input  logic                         rst,
	input  logic                         io_enable,
	input  logic                         io_strobe,
	input  logic [15:0]                  io_din,
	output logic                         word_stb,
	output logic [hps_io_pkg::cnt_w-1:0] word_idx,
	output logic [15:0]                  word_data,
	output logic [15:0]                  cmd,
	output logic                         frame_end
);

	// set by the first strobe so empty transfers give no frame_end
	logic in_xfer;

	assign word_stb  = io_enable & io_strobe;
	assign word_data = io_din;

	// first low cycle of io_enable after a transfer with words
	assign frame_end = in_xfer & ~io_enable;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			in_xfer  <= 1'b0;
			word_idx <= '0;
			cmd      <= '0;
		end else if (!io_enable) begin
			// back to waiting for a command word
			in_xfer  <= 1'b0;
			word_idx <= '0;
			cmd      <= '0;
		end else if (io_strobe) begin
			in_xfer <= 1'b1;
			if (word_idx == '0) begin
				cmd <= io_din;
			end
			// long transfers keep reporting the last index
			if (word_idx != '1) begin
				word_idx <= word_idx + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// counter holds at its top value for the rest of the transfer
	idx_saturates_a : assert property (
		@(posedge clk_sys) disable iff (rst)
		(io_enable && word_idx == '1) |=> (word_idx == '1)
	);

endmodule

// File: hps_io_pkg.sv
package hps_io_pkg;

	////////////////////////////////////////////////////////////
	// host channel geometry
	////////////////////////////////////////////////////////////

	localparam int word_w = 16;
	// argument word counter, saturates at all ones
	localparam int cnt_w = 4;

	// command channel opcodes (word 0 of an io_enable transfer)
	localparam logic [word_w-1:0] cmd_cfg        = 16'h0001;
	localparam logic [word_w-1:0] cmd_joy0       = 16'h0002;
	localparam logic [word_w-1:0] cmd_joy1       = 16'h0003;
	localparam logic [word_w-1:0] cmd_key        = 16'h0005;
	localparam logic [word_w-1:0] cmd_status     = 16'h001E;
	localparam logic [word_w-1:0] cmd_status_req = 16'h0029;

	// upper nibble of the status request reply
	localparam logic [3:0] req_tag = 4'hA;

	////////////////////////////////////////////////////////////
	// file channel
	////////////////////////////////////////////////////////////

	localparam logic [7:0] fio_tx     = 8'h53;
	localparam logic [7:0] fio_tx_dat = 8'h54;
	localparam logic [7:0] fio_index  = 8'h55;

	localparam int addr_w = 27;
	localparam int data_w = 8;

	////////////////////////////////////////////////////////////
	// ps/2 scan code handling
	////////////////////////////////////////////////////////////

	localparam logic [7:0] key_break = 8'hF0;
	localparam logic [7:0] key_ext   = 8'hE0;

	// whole byte sequences, newest byte in the low bits
	localparam logic [31:0] key_prnscr_make  = 32'hE012E07C;
	localparam logic [31:0] key_prnscr_break = 32'h7CE0F012;
	localparam logic [31:0] key_pause_make   = 32'hF014F077;

	// bit 9 set means pressed, release clears it
	localparam logic [9:0] key_prnscr_code = 10'h37C;
	localparam logic [9:0] key_pause_code  = 10'h377;

endpackage
